// File: id_stage.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_latch.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_bypass.sv
source/branch_unit.sv
source/id_stage.sv
tb/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f id_stage.f \
    --top-module tb_id_stage -o tb_id_stage > build.log 2>&1 &&
./obj_dir/tb_id_stage > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int test_cycles = 200;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 fs_valid, rf_we, exe_gr_we, mem_gr_we, wb_gr_we;
    logic                 es_load_valid, es_allowin;
    logic [31:0]          fs_inst, fs_pc, rf_wdata, exe_result, mem_result, wb_result;
    logic [4:0]           rf_waddr, exe_dest, mem_dest, wb_dest;
    logic                 ds_allowin, es_valid, es_load, es_store, es_src1_is_pc;
    logic                 es_src2_is_imm, es_gr_we, br_taken;
    logic [alu_op_w-1:0]  es_alu_op;
    logic [md_op_w-1:0]   es_md_op;
    logic [reg_idx_w-1:0] es_dest;
    logic [31:0]          es_imm, es_rj_value, es_rkd_value, es_pc, br_target;

    logic [31:0] shadow [32];
    logic [31:0] departed [$];
    int          seed = 7532;
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    string       cur_test = "reset";

    // register-register ops of the first test, with their one-hot expectations
    logic [4:0] fns [7] = '{fn_add, fn_sub, fn_slt, fn_and, fn_nor, fn_mul, fn_div};
    int         alu_bits [7] = '{alu_add, alu_sub, alu_slt, alu_and, alu_nor, -1, -1};
    logic [6:0] md_ops [7] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h40, 7'h08};

    id_stage u_dut (.*);

    always #5 clk = ~clk;

    initial begin
        #(test_cycles * 10 + 500);
        $display("watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

    // an instruction leaves at the rising edge after this sample
    always @(negedge clk) begin
        if (!reset && es_valid && es_allowin) begin
            departed.push_back(es_pc);
        end
    end

    assert property (@(posedge clk) disable iff (reset) br_taken |-> (es_valid && es_allowin))
    else begin
        $display("[ERROR] %s br_taken without departure expected 0 actual 1", cur_test);
        test_errs++;
    end

    function automatic logic [31:0] enc_reg3(input logic [1:0] sub, input logic [4:0] fn,
                                             input logic [4:0] rk, rj, rd);
        return {op_alu, grp_reg3, sub, fn, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [5:0] op, input logic [3:0] grp,
                                            input logic [11:0] i12, input logic [4:0] rj, rd);
        return {op, grp, i12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i16(input logic [5:0] op, input logic [15:0] offs,
                                            input logic [4:0] rj, rd);
        return {op, offs, rj, rd};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s: ok", cur_test);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic rf_write(input logic [4:0] addr, input logic [31:0] val);
        tick();
        rf_we = 1'b1;
        rf_waddr = addr;
        rf_wdata = val;
        tick();
        rf_we = 1'b0;
        if (addr != 5'd0) begin
            shadow[addr] = val;
        end
    endtask

    // returns with the instruction in decode and its outputs settled
    task automatic issue(input logic [31:0] inst, pc, input logic follow);
        tick();
        fs_valid = 1'b1;
        fs_inst = inst;
        fs_pc = pc;
        #2;
        while (!ds_allowin) begin
            @(posedge clk);
            #3;
        end
        tick();
        fs_valid = follow;
        fs_inst = enc_reg3(sub_reg3, fn_add, 5'd2, 5'd1, 5'd3);
        fs_pc = pc + 4;
        #2;
    endtask

    task automatic imm_case(input logic [31:0] inst, exp_imm);
        issue(inst, 32'h200, 1'b0);
        check("imm", exp_imm, es_imm);
        check("src2_is_imm", 1, es_src2_is_imm);
    endtask

    // the follower is fetched while the branch sits in decode
    task automatic branch_case(input logic [31:0] inst, pc, input logic exp_taken,
                               input logic [31:0] exp_target);
        issue(inst, pc, 1'b1);
        check("br_taken", exp_taken, br_taken);
        if (exp_taken) begin
            check("br_target", exp_target, br_target);
        end
        if (inst[31:26] == op_bl) begin
            check("bl dest", link_reg, es_dest);
            check("bl imm", 4, es_imm);
            check("bl src1_is_pc", 1, es_src1_is_pc);
        end
        tick();
        fs_valid = 1'b0;
        #2;
        check("follower valid", !exp_taken, es_valid);
        if (!exp_taken) begin
            check("follower pc", pc + 4, es_pc);
        end
    endtask

    initial begin
        logic [4:0]  rj, rk, rd;
        logic [11:0] i12;
        logic [19:0] si20;
        logic [15:0] o16;
        logic [25:0] o26;

        reset = 1'b1;
        {fs_valid, rf_we, exe_gr_we, mem_gr_we, wb_gr_we, es_load_valid} = '0;
        {fs_inst, fs_pc, rf_wdata, exe_result, mem_result, wb_result} = '0;
        {rf_waddr, exe_dest, mem_dest, wb_dest} = '0;
        es_allowin = 1'b1;
        shadow[0] = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        #2;
        check("ds_allowin", 1, ds_allowin);
        check("es_valid", 0, es_valid);
        check("br_taken", 0, br_taken);

        cur_test = "reg3";
        for (int r = 0; r < 32; r++) begin
            rf_write(r[4:0], $random(seed));
        end
        for (int i = 0; i < 7; i++) begin
            rj = (i == 0) ? 5'd0 : 5'($random(seed));
            rk = 5'($random(seed));
            rd = 5'($random(seed));
            issue(enc_reg3((i == 6) ? sub_divmod : sub_reg3, fns[i], rk, rj, rd),
                  32'h100 + 4 * i, 1'b0);
            check("alu_op", (alu_bits[i] < 0) ? 0 : 1 << alu_bits[i], es_alu_op);
            check("md_op", md_ops[i], es_md_op);
            check("dest", rd, es_dest);
            check("gr_we", 1, es_gr_we);
            check("src2_is_imm", 0, es_src2_is_imm);
            check("src1_is_pc", 0, es_src1_is_pc);
            check("rj value", shadow[rj], es_rj_value);
            check("rk value", shadow[rk], es_rkd_value);
        end
        finish_test();

        cur_test = "imm_mem";
        i12 = 12'($random(seed));
        si20 = 20'($random(seed));
        imm_case(enc_i12(op_alu, grp_addi, i12, 5'd8, 5'd9), {{20{i12[11]}}, i12});
        imm_case(enc_i12(op_alu, grp_andi, i12, 5'd8, 5'd9), {20'b0, i12});
        imm_case({op_lu12i, 1'b0, si20, 5'd9}, {si20, 12'b0});
        imm_case({op_pcaddu12i, 1'b0, si20, 5'd9}, {si20, 12'b0});
        check("src1_is_pc", 1, es_src1_is_pc);
        imm_case({op_alu, grp_shift_imm, sub_shift, fn_slli, 5'd3, 5'd8, 5'd9},
                 {20'b0, sub_shift, fn_slli, 5'd3});
        imm_case(enc_i12(op_ldst, grp_ld_w, i12, 5'd8, 5'd9), {{20{i12[11]}}, i12});
        check("load", 1, es_load);
        check("gr_we", 1, es_gr_we);
        imm_case(enc_i12(op_ldst, grp_st_w, i12, 5'd8, 5'd10), {{20{i12[11]}}, i12});
        check("store", 1, es_store);
        check("gr_we", 0, es_gr_we);
        check("rd value", shadow[10], es_rkd_value);
        finish_test();

        cur_test = "forwarding";
        tick();
        es_allowin = 1'b0;
        issue(enc_reg3(sub_reg3, fn_add, 5'd12, 5'd11, 5'd13), 32'h300, 1'b0);
        tick();
        {exe_gr_we, exe_dest, exe_result} = {1'b1, 5'd11, 32'($random(seed))};
        {mem_gr_we, mem_dest, mem_result} = {1'b1, 5'd11, 32'($random(seed))};
        {wb_gr_we, wb_dest, wb_result} = {1'b1, 5'd11, 32'($random(seed))};
        #2;
        check("exe over mem", exe_result, es_rj_value);
        tick();
        exe_gr_we = 1'b0;
        #2;
        check("mem over wb", mem_result, es_rj_value);
        tick();
        mem_gr_we = 1'b0;
        #2;
        check("wb over rf", wb_result, es_rj_value);
        tick();
        wb_gr_we = 1'b0;
        #2;
        check("rf only", shadow[11], es_rj_value);
        check("rk rf only", shadow[12], es_rkd_value);
        tick();
        {exe_gr_we, exe_dest, mem_gr_we, mem_dest, wb_gr_we, wb_dest} = {3{1'b1, 5'd0}};
        es_allowin = 1'b1;
        issue(enc_reg3(sub_reg3, fn_or, 5'd0, 5'd0, 5'd13), 32'h304, 1'b0);
        check("r0 rj", 0, es_rj_value);
        check("r0 rk", 0, es_rkd_value);
        tick();
        {exe_gr_we, mem_gr_we, wb_gr_we} = 3'b000;
        finish_test();

        cur_test = "load_use";
        departed.delete();
        es_load_valid = 1'b1;
        {exe_gr_we, exe_dest} = {1'b1, 5'd14};
        issue(enc_reg3(sub_reg3, fn_add, 5'd15, 5'd14, 5'd16), 32'h400, 1'b0);
        repeat (2) begin
            check("es_valid", 0, es_valid);
            check("ds_allowin", 0, ds_allowin);
            check("held pc", 32'h400, es_pc);
            tick();
            #2;
        end
        tick();
        {es_load_valid, exe_gr_we} = 2'b00;
        #2;
        check("es_valid", 1, es_valid);
        repeat (2) tick();
        check("departures", 1, departed.size());
        check("departed pc", 32'h400, departed[0]);
        finish_test();

        cur_test = "branch";
        o16 = 16'($random(seed));
        o26 = 26'($random(seed));
        branch_case(enc_i16(op_beq, o16, 5'd4, 5'd4), 32'h1000, 1'b1,
                    32'h1000 + {{14{o16[15]}}, o16, 2'b0});
        branch_case(enc_i16(op_beq, o16, 5'd4, 5'd5), 32'h1100, shadow[4] == shadow[5],
                    32'h1100 + {{14{o16[15]}}, o16, 2'b0});
        branch_case(enc_i16(op_bne, o16, 5'd4, 5'd5), 32'h1200, shadow[4] != shadow[5],
                    32'h1200 + {{14{o16[15]}}, o16, 2'b0});
        branch_case(enc_i16(op_bne, o16, 5'd6, 5'd6), 32'h1300, 1'b0, 32'h0);
        branch_case(enc_i16(op_b, o26[15:0], o26[25:21], o26[20:16]), 32'h1400, 1'b1,
                    32'h1400 + {{4{o26[25]}}, o26, 2'b0});
        branch_case(enc_i16(op_bl, o26[15:0], o26[25:21], o26[20:16]), 32'h1500, 1'b1,
                    32'h1500 + {{4{o26[25]}}, o26, 2'b0});
        branch_case(enc_i16(op_jirl, o16, 5'd7, 5'd0), 32'h1600, 1'b1,
                    shadow[7] + {{14{o16[15]}}, o16, 2'b0});
        finish_test();

        cur_test = "backpressure";
        tick();
        es_allowin = 1'b0;
        departed.delete();
        issue(enc_reg3(sub_reg3, fn_xor, 5'd18, 5'd17, 5'd19), 32'h600, 1'b1);
        repeat (3) begin
            check("ds_allowin", 0, ds_allowin);
            check("held pc", 32'h600, es_pc);
            check("held rj", shadow[17], es_rj_value);
            tick();
            #2;
        end
        tick();
        es_allowin = 1'b1;
        tick();
        fs_valid = 1'b0;
        repeat (2) tick();
        check("departures", 2, departed.size());
        check("first pc", 32'h600, departed[0]);
        check("second pc", 32'h604, departed[1]);
        es_allowin = 1'b0;
        issue(enc_i16(op_b, 16'h0010, 5'd0, 5'd0), 32'h700, 1'b0);
        repeat (2) begin
            check("br_taken held", 0, br_taken);
            tick();
            #2;
        end
        tick();
        es_allowin = 1'b1;
        #2;
        check("br_taken", 1, br_taken);
        check("br_target", 32'h740, br_target);
        tick();
        finish_test();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fs_valid,
    input  logic [inst_w-1:0]    fs_inst,
    input  logic [pc_w-1:0]      fs_pc,
    output logic                 ds_allowin,
    input  logic                 rf_we,
    input  logic [reg_idx_w-1:0] rf_waddr,
    input  logic [xlen-1:0]      rf_wdata,
    input  logic                 exe_gr_we,
    input  logic [reg_idx_w-1:0] exe_dest,
    input  logic [xlen-1:0]      exe_result,
    input  logic                 mem_gr_we,
    input  logic [reg_idx_w-1:0] mem_dest,
    input  logic [xlen-1:0]      mem_result,
    input  logic                 wb_gr_we,
    input  logic [reg_idx_w-1:0] wb_dest,
    input  logic [xlen-1:0]      wb_result,
    input  logic                 es_load_valid,
    input  logic                 es_allowin,
    output logic                 es_valid,
    output logic [alu_op_w-1:0]  es_alu_op,
    output logic [md_op_w-1:0]   es_md_op,
    output logic                 es_load,
    output logic                 es_store,
    output logic                 es_src1_is_pc,
    output logic                 es_src2_is_imm,
    output logic                 es_gr_we,
    output logic [reg_idx_w-1:0] es_dest,
    output logic [xlen-1:0]      es_imm,
    output logic [xlen-1:0]      es_rj_value,
    output logic [xlen-1:0]      es_rkd_value,
    output logic [pc_w-1:0]      es_pc,
    output logic                 br_taken,
    output logic [pc_w-1:0]      br_target
);

    logic                 ds_valid;
    logic [inst_w-1:0]    ds_inst;
    logic [reg_idx_w-1:0] raddr1, raddr2;
    logic                 rd1_en, rd2_en;
    logic [xlen-1:0]      rf_rdata1, rf_rdata2;
    logic                 ready_go;
    logic                 is_beq, is_bne, is_b, is_bl, is_jirl;
    logic [pc_w-1:0]      br_offs;

    assign es_valid   = ds_valid && ready_go;
    assign ds_allowin = !ds_valid || (es_valid && es_allowin);

    fetch_latch u_latch (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fs_inst    (fs_inst),
        .fs_pc      (fs_pc),
        .ds_allowin (ds_allowin),
        .br_flush   (br_taken),
        .ds_valid   (ds_valid),
        .ds_inst    (ds_inst),
        .ds_pc      (es_pc)
    );

    inst_decoder u_decoder (
        .inst        (ds_inst),
        .alu_op      (es_alu_op),
        .md_op       (es_md_op),
        .load        (es_load),
        .store       (es_store),
        .src1_is_pc  (es_src1_is_pc),
        .src2_is_imm (es_src2_is_imm),
        .gr_we       (es_gr_we),
        .dest        (es_dest),
        .imm         (es_imm),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rd1_en      (rd1_en),
        .rd2_en      (rd2_en),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_b        (is_b),
        .is_bl       (is_bl),
        .is_jirl     (is_jirl),
        .br_offs     (br_offs)
    );

    regfile #(.addr_w(reg_idx_w)) u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    operand_bypass #(.addr_w(reg_idx_w)) u_bypass (
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .rd1_en        (rd1_en),
        .rd2_en        (rd2_en),
        .rf_rdata1     (rf_rdata1),
        .rf_rdata2     (rf_rdata2),
        .exe_gr_we     (exe_gr_we),
        .exe_dest      (exe_dest),
        .exe_result    (exe_result),
        .mem_gr_we     (mem_gr_we),
        .mem_dest      (mem_dest),
        .mem_result    (mem_result),
        .wb_gr_we      (wb_gr_we),
        .wb_dest       (wb_dest),
        .wb_result     (wb_result),
        .es_load_valid (es_load_valid),
        .rj_value      (es_rj_value),
        .rkd_value     (es_rkd_value),
        .ready_go      (ready_go)
    );

    branch_unit u_branch (
        .ds_valid   (ds_valid),
        .ready_go   (ready_go),
        .es_allowin (es_allowin),
        .is_beq     (is_beq),
        .is_bne     (is_bne),
        .is_b       (is_b),
        .is_bl      (is_bl),
        .is_jirl    (is_jirl),
        .br_offs    (br_offs),
        .rj_value   (es_rj_value),
        .rkd_value  (es_rkd_value),
        .ds_pc      (es_pc),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import pipe_pkg::*; (
    input  logic            ds_valid,
    input  logic            ready_go,
    input  logic            es_allowin,
    input  logic            is_beq,
    input  logic            is_bne,
    input  logic            is_b,
    input  logic            is_bl,
    input  logic            is_jirl,
    input  logic [pc_w-1:0] br_offs,
    input  logic [xlen-1:0] rj_value,
    input  logic [xlen-1:0] rkd_value,
    input  logic [pc_w-1:0] ds_pc,
    output logic            br_taken,
    output logic [pc_w-1:0] br_target
);

    logic ops_equal;
    logic cond;
    logic leaving;

    assign ops_equal = rj_value == rkd_value;
    assign cond      = (is_beq && ops_equal) || (is_bne && !ops_equal)
                    || is_b || is_bl || is_jirl;

    // only strobe when the branch actually moves to execute
    assign leaving  = ds_valid && ready_go && es_allowin;
    assign br_taken = leaving && cond;

    // jirl offset is already the si16 form
    assign br_target = (is_jirl ? pc_w'(rj_value) : ds_pc) + br_offs;

endmodule

// File: source/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import pipe_pkg::*; #(
    parameter int addr_w = 5
) (
    input  logic [addr_w-1:0] raddr1,
    input  logic [addr_w-1:0] raddr2,
    input  logic              rd1_en,
    input  logic              rd2_en,
    input  logic [xlen-1:0]   rf_rdata1,
    input  logic [xlen-1:0]   rf_rdata2,
    input  logic              exe_gr_we,
    input  logic [addr_w-1:0] exe_dest,
    input  logic [xlen-1:0]   exe_result,
    input  logic              mem_gr_we,
    input  logic [addr_w-1:0] mem_dest,
    input  logic [xlen-1:0]   mem_result,
    input  logic              wb_gr_we,
    input  logic [addr_w-1:0] wb_dest,
    input  logic [xlen-1:0]   wb_result,
    input  logic              es_load_valid,
    output logic [xlen-1:0]   rj_value,
    output logic [xlen-1:0]   rkd_value,
    output logic              ready_go
);

    // youngest producer wins
    function automatic logic [xlen-1:0] pick(
        input logic [addr_w-1:0] addr,
        input logic              en,
        input logic [xlen-1:0]   rf_val
    );
        logic live;
        live = en && addr != '0;
        if (live && exe_gr_we && exe_dest == addr) begin
            return exe_result;
        end else if (live && mem_gr_we && mem_dest == addr) begin
            return mem_result;
        end else if (live && wb_gr_we && wb_dest == addr) begin
            return wb_result;
        end
        return rf_val;
    endfunction

    assign rj_value  = pick(raddr1, rd1_en, rf_rdata1);
    assign rkd_value = pick(raddr2, rd2_en, rf_rdata2);

    // load data not ready until it reaches mem
    assign ready_go = !(es_load_valid && ((rd1_en && exe_dest == raddr1)
                                       || (rd2_en && exe_dest == raddr2)));

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

module regfile import pipe_pkg::*; #(
    parameter int addr_w = 5
) (
    input  logic              clk,
    input  logic [addr_w-1:0] raddr1,
    input  logic [addr_w-1:0] raddr2,
    output logic [xlen-1:0]   rdata1,
    output logic [xlen-1:0]   rdata2,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [xlen-1:0]   wdata
);

    logic [xlen-1:0] regs [0:2**addr_w-1];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  logic [inst_w-1:0]    inst,
    output logic [alu_op_w-1:0]  alu_op,
    output logic [md_op_w-1:0]   md_op,
    output logic                 load,
    output logic                 store,
    output logic                 src1_is_pc,
    output logic                 src2_is_imm,
    output logic                 gr_we,
    output logic [reg_idx_w-1:0] dest,
    output logic [xlen-1:0]      imm,
    output logic [reg_idx_w-1:0] raddr1,
    output logic [reg_idx_w-1:0] raddr2,
    output logic                 rd1_en,
    output logic                 rd2_en,
    output logic                 is_beq,
    output logic                 is_bne,
    output logic                 is_b,
    output logic                 is_bl,
    output logic                 is_jirl,
    output logic [pc_w-1:0]      br_offs
);

    logic [5:0]           op_31_26;
    logic [3:0]           op_25_22;
    logic [1:0]           op_21_20;
    logic [4:0]           op_19_15;
    logic [reg_idx_w-1:0] rd, rj, rk;
    logic [11:0]          i12;
    logic [19:0]          i20;
    logic [15:0]          i16;
    logic [25:0]          i26;
    logic                 is_reg3, is_shift, is_divmod, is_alu_grp;
    logic                 add_w, sub_w, slt, sltu, and_w, nor_w, or_w, xor_w;
    logic                 sll_w, srl_w, sra_w, slli_w, srli_w, srai_w;
    logic                 mul_w, mulh_w, mulh_wu, div_w, mod_w, div_wu, mod_wu;
    logic                 addi_w, slti, sltui, andi, ori, xori;
    logic                 ld_w, st_w, lu12i_w, pcaddu12i;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_alu_grp = op_31_26 == op_alu;
    assign is_reg3    = is_alu_grp && op_25_22 == grp_reg3 && op_21_20 == sub_reg3;
    assign is_shift   = is_alu_grp && op_25_22 == grp_shift_imm && op_21_20 == sub_shift;
    assign is_divmod  = is_alu_grp && op_25_22 == grp_reg3 && op_21_20 == sub_divmod;

    assign add_w   = is_reg3 && op_19_15 == fn_add;
    assign sub_w   = is_reg3 && op_19_15 == fn_sub;
    assign slt     = is_reg3 && op_19_15 == fn_slt;
    assign sltu    = is_reg3 && op_19_15 == fn_sltu;
    assign nor_w   = is_reg3 && op_19_15 == fn_nor;
    assign and_w   = is_reg3 && op_19_15 == fn_and;
    assign or_w    = is_reg3 && op_19_15 == fn_or;
    assign xor_w   = is_reg3 && op_19_15 == fn_xor;
    assign sll_w   = is_reg3 && op_19_15 == fn_sll;
    assign srl_w   = is_reg3 && op_19_15 == fn_srl;
    assign sra_w   = is_reg3 && op_19_15 == fn_sra;
    assign mul_w   = is_reg3 && op_19_15 == fn_mul;
    assign mulh_w  = is_reg3 && op_19_15 == fn_mulh;
    assign mulh_wu = is_reg3 && op_19_15 == fn_mulhu;
    assign slli_w  = is_shift && op_19_15 == fn_slli;
    assign srli_w  = is_shift && op_19_15 == fn_srli;
    assign srai_w  = is_shift && op_19_15 == fn_srai;
    assign div_w   = is_divmod && op_19_15 == fn_div;
    assign mod_w   = is_divmod && op_19_15 == fn_mod;
    assign div_wu  = is_divmod && op_19_15 == fn_divu;
    assign mod_wu  = is_divmod && op_19_15 == fn_modu;

    assign slti      = is_alu_grp && op_25_22 == grp_slti;
    assign sltui     = is_alu_grp && op_25_22 == grp_sltui;
    assign addi_w    = is_alu_grp && op_25_22 == grp_addi;
    assign andi      = is_alu_grp && op_25_22 == grp_andi;
    assign ori       = is_alu_grp && op_25_22 == grp_ori;
    assign xori      = is_alu_grp && op_25_22 == grp_xori;
    assign ld_w      = op_31_26 == op_ldst && op_25_22 == grp_ld_w;
    assign st_w      = op_31_26 == op_ldst && op_25_22 == grp_st_w;
    // bit 25 clear separates these from neighbouring encodings
    assign lu12i_w   = op_31_26 == op_lu12i && !inst[25];
    assign pcaddu12i = op_31_26 == op_pcaddu12i && !inst[25];
    assign is_jirl   = op_31_26 == op_jirl;
    assign is_b      = op_31_26 == op_b;
    assign is_bl     = op_31_26 == op_bl;
    assign is_beq    = op_31_26 == op_beq;
    assign is_bne    = op_31_26 == op_bne;

    always_comb begin
        alu_op           = '0;
        alu_op[alu_add]  = add_w | addi_w | ld_w | st_w | is_jirl | is_bl | pcaddu12i;
        alu_op[alu_sub]  = sub_w;
        alu_op[alu_slt]  = slt | slti;
        alu_op[alu_sltu] = sltu | sltui;
        alu_op[alu_and]  = and_w | andi;
        alu_op[alu_nor]  = nor_w;
        alu_op[alu_or]   = or_w | ori;
        alu_op[alu_xor]  = xor_w | xori;
        alu_op[alu_sll]  = sll_w | slli_w;
        alu_op[alu_srl]  = srl_w | srli_w;
        alu_op[alu_sra]  = sra_w | srai_w;
        alu_op[alu_lui]  = lu12i_w;
    end

    assign md_op = {mul_w, mulh_w, mulh_wu, div_w, mod_w, div_wu, mod_wu};

    // return address offset first, then the wide forms
    always_comb begin
        if (is_jirl || is_bl) begin
            imm = xlen'(4);
        end else if (lu12i_w || pcaddu12i) begin
            imm = {i20, 12'b0};
        end else if (andi || ori || xori) begin
            imm = {20'b0, i12};
        end else begin
            imm = {{20{i12[11]}}, i12};
        end
    end

    assign br_offs = (is_b || is_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                     : {{14{i16[15]}}, i16, 2'b0};

    assign load        = ld_w;
    assign store       = st_w;
    assign src1_is_pc  = is_jirl | is_bl | pcaddu12i;
    assign src2_is_imm = slli_w | srli_w | srai_w | slti | sltui | addi_w | andi | ori
                       | xori | ld_w | st_w | lu12i_w | pcaddu12i | is_jirl | is_bl;
    assign gr_we       = !(st_w || is_beq || is_bne || is_b);
    assign dest        = is_bl ? reg_idx_w'(link_reg) : rd;

    assign raddr1 = rj;
    assign raddr2 = (is_beq || is_bne || st_w) ? rd : rk;
    assign rd2_en = is_reg3 | is_divmod | st_w | is_beq | is_bne;
    assign rd1_en = rd2_en | is_shift | slti | sltui | addi_w | andi | ori | xori
                  | ld_w | is_jirl;

endmodule

// File: source/fetch_latch.sv
`timescale 1ns/1ps

module fetch_latch import pipe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              fs_valid,
    input  logic [inst_w-1:0] fs_inst,
    input  logic [pc_w-1:0]   fs_pc,
    input  logic              ds_allowin,
    input  logic              br_flush,
    output logic              ds_valid,
    output logic [inst_w-1:0] ds_inst,
    output logic [pc_w-1:0]   ds_pc
);

    // taken branch kills whatever fetch offers in the same cycle
    always_ff @(posedge clk) begin
        if (reset || br_flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    // datapath and address widths
    localparam int xlen   = 32;
    localparam int pc_w   = 32;
    localparam int inst_w = 32;

    // bl writes its return address here
    localparam int link_reg = 1;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

    localparam int reg_idx_w = 5;
    localparam int alu_op_w  = 12;
    localparam int md_op_w   = 7;

    // bit positions in the one-hot alu operation
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // major opcode, bits 31:26
    localparam logic [5:0] op_alu       = 6'h00;
    localparam logic [5:0] op_lu12i     = 6'h05;
    localparam logic [5:0] op_pcaddu12i = 6'h07;
    localparam logic [5:0] op_ldst      = 6'h0a;
    localparam logic [5:0] op_jirl      = 6'h13;
    localparam logic [5:0] op_b         = 6'h14;
    localparam logic [5:0] op_bl        = 6'h15;
    localparam logic [5:0] op_beq       = 6'h16;
    localparam logic [5:0] op_bne       = 6'h17;

    // group, bits 25:22
    localparam logic [3:0] grp_reg3      = 4'h0;
    localparam logic [3:0] grp_shift_imm = 4'h1;
    localparam logic [3:0] grp_ld_w      = 4'h2;
    localparam logic [3:0] grp_st_w      = 4'h6;
    localparam logic [3:0] grp_slti      = 4'h8;
    localparam logic [3:0] grp_sltui     = 4'h9;
    localparam logic [3:0] grp_addi      = 4'ha;
    localparam logic [3:0] grp_andi      = 4'hd;
    localparam logic [3:0] grp_ori       = 4'he;
    localparam logic [3:0] grp_xori      = 4'hf;

    // bits 21:20
    localparam logic [1:0] sub_shift  = 2'h0;
    localparam logic [1:0] sub_reg3   = 2'h1;
    localparam logic [1:0] sub_divmod = 2'h2;

    // function codes, bits 19:15
    localparam logic [4:0] fn_add   = 5'h00;
    localparam logic [4:0] fn_sub   = 5'h02;
    localparam logic [4:0] fn_slt   = 5'h04;
    localparam logic [4:0] fn_sltu  = 5'h05;
    localparam logic [4:0] fn_nor   = 5'h08;
    localparam logic [4:0] fn_and   = 5'h09;
    localparam logic [4:0] fn_or    = 5'h0a;
    localparam logic [4:0] fn_xor   = 5'h0b;
    localparam logic [4:0] fn_sll   = 5'h0e;
    localparam logic [4:0] fn_srl   = 5'h0f;
    localparam logic [4:0] fn_sra   = 5'h10;
    localparam logic [4:0] fn_mul   = 5'h18;
    localparam logic [4:0] fn_mulh  = 5'h19;
    localparam logic [4:0] fn_mulhu = 5'h1a;
    // shift-immediate group
    localparam logic [4:0] fn_slli  = 5'h01;
    localparam logic [4:0] fn_srli  = 5'h09;
    localparam logic [4:0] fn_srai  = 5'h11;
    // divide group
    localparam logic [4:0] fn_div   = 5'h00;
    localparam logic [4:0] fn_mod   = 5'h01;
    localparam logic [4:0] fn_divu  = 5'h02;
    localparam logic [4:0] fn_modu  = 5'h03;

endpackage
